// ==== hdl/canmon_settings.svh ====
// CANopen activity monitor settings
// Frame layout widths, SDO COB-ID bases and command bytes,
// the oscillator trim pattern and the verdict counter width.

`ifndef CANMON_SETTINGS_SVH
`define CANMON_SETTINGS_SVH

// frame layout, 12-bit COB-ID followed by 8 data bytes
`define FRAME_WIDTH 76
`define COB_ID_WIDTH 12

// SDO COB-ID bases, node id is added on top
`define SDO_REQ_BASE 12'h600
`define SDO_RESP_BASE 12'h580

// SDO command bytes
`define CMD_READ_REQ 8'h40   // upload request
`define CMD_READ_RESP 8'h43  // expedited upload response, 4 bytes
`define CMD_WRITE_REQ 8'h23  // expedited download request, 4 bytes
`define CMD_WRITE_ACK 8'h60  // download acknowledge

// oscillator trim pattern
`define TRIM_COB_ID 12'h555
`define TRIM_DATA 64'hAAAA_AAAA_AAAA_AAAA

// low bits of a frame that the echo check does not compare
`define ECHO_IGNORE_BITS 8

// width of the good and bad verdict counters
`define COUNT_WIDTH 16

`endif

// ==== hdl/canMonPkg.sv ====
// CANopen activity monitor types
// Frame layout as seen on the hub, the test mode that picks the
// request source, and the rule classes used to judge a response.

package canMonPkg;

`include "canmon_settings.svh"

   // one CAN frame as carried between hub and bus
   // cobId sits in the top bits, value in the lowest 32
   typedef struct packed
   {
      logic [`COB_ID_WIDTH-1:0] cobId;
      logic [7:0]               cmd;        // SDO command specifier
      logic [15:0]              index;      // object dictionary index
      logic [7:0]               subIndex;
      logic [31:0]              value;      // payload data bytes
   } frameT;

   // request source selection
   //  modeNormal  : uplink frame
   //  modeOscTrim : fixed trim pattern
   //  modeRx      : uplink frame
   //  modeTx      : downlink frame
   //  modeCustom  : decoded bus frame
   typedef enum logic [2:0]
   {
      modeNormal,
      modeOscTrim,
      modeRx,
      modeTx,
      modeCustom
   } testModeT;

   // rule class that judged a request/response pair
   typedef enum logic [1:0]
   {
      ruleTrim,      // trim echo with bus id in the payload
      ruleSdoRead,   // SDO upload response
      ruleSdoWrite,  // SDO download acknowledge
      ruleEcho       // everything else, echo above the low byte
   } ruleT;

endpackage

// ==== hdl/frameCapture.sv ====
// Frame capture stage of the CANopen activity monitor
// Holds the latest request, taken from the source that the test mode
// selects, and freezes the request/response pair on every response
// strobe so later requests cannot disturb a pair in flight.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module frameCapture
   import canMonPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  testModeT testMode,
   input  frameT    uplinkFrame,
   input  frameT    downlinkFrame,
   input  frameT    decodedFrame,
   input  logic     reqMsg,
   input  logic     respMsg,
   output frameT    pairRequest,
   output frameT    pairResponse,
   output logic     pairValid
);

   frameT trimPattern;
   frameT reqSource;   // request candidate for the current mode
   frameT reqReg;      // latest request seen

   assign trimPattern = {`TRIM_COB_ID, `TRIM_DATA};

   // request source by mode
   always_comb
   begin
      case (testMode)
         modeOscTrim:
         begin
            reqSource = trimPattern;
         end
         modeTx:
         begin
            reqSource = downlinkFrame;
         end
         modeCustom:
         begin
            reqSource = decodedFrame;
         end
         default:
         begin
            reqSource = uplinkFrame;   // normal and rx
         end
      endcase
   end

   // request register, cleared so an early response sees all zeros
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         reqReg <= '0;
      end
      else if (reqMsg)
      begin
         reqReg <= reqSource;
      end
   end

   // pair snapshot; reqReg here is the value from before this edge,
   // so a request in the same cycle only affects the next pair
   always_ff @(posedge clk)
   begin
      if (respMsg)
      begin
         pairRequest  <= reqReg;
         pairResponse <= uplinkFrame;   // responses come back on the uplink
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         pairValid <= 1'b0;
      end
      else
      begin
         pairValid <= respMsg;
      end
   end

endmodule

// ==== hdl/sdoRuleCheck.sv ====
// SDO rule check stage of the CANopen activity monitor
// Sorts a captured request/response pair into one of four rule classes
// by the request's COB-ID and command byte, judges the response
// against that rule and registers the verdict with a valid pulse.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module sdoRuleCheck
   import canMonPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] busId,
   input  frameT      pairRequest,
   input  frameT      pairResponse,
   input  logic       pairValid,
   output logic       verdictValid,
   output logic       verdictGood,
   output ruleT       verdictRule
);

   frameT                    trimPattern;
   frameT                    trimExpect;
   logic [`COB_ID_WIDTH-1:0] respCobExpect;
   logic                     inSdoRange;
   logic                     sdoHeaderOk;
   logic                     goodTrim;
   logic                     goodRead;
   logic                     goodWrite;
   logic                     goodEcho;
   ruleT                     ruleSel;
   logic                     goodSel;

   assign trimPattern = {`TRIM_COB_ID, `TRIM_DATA};

   // chip answers the trim pattern with its bus id in the top value byte
   always_comb
   begin
      trimExpect              = trimPattern;
      trimExpect.value[31:24] = busId;
   end

   // node ids 1..127 on top of the request base
   assign inSdoRange = (pairRequest.cobId > `SDO_REQ_BASE) &&
                       (pairRequest.cobId < (`SDO_REQ_BASE + 12'h080));

   // response goes back on the same node, shifted to the response base
   assign respCobExpect = pairRequest.cobId - (`SDO_REQ_BASE - `SDO_RESP_BASE);

   // common to read and write, addressed object must match
   assign sdoHeaderOk = (pairResponse.cobId == respCobExpect) &&
                        (pairResponse.index == pairRequest.index) &&
                        (pairResponse.subIndex == pairRequest.subIndex);

   assign goodTrim = (pairResponse == trimExpect);

   // value of a read is not judged
   assign goodRead = sdoHeaderOk && (pairResponse.cmd == `CMD_READ_RESP);

   assign goodWrite = sdoHeaderOk &&
                      (pairResponse.cmd == `CMD_WRITE_ACK) &&
                      (pairResponse.value == 32'h0);

   assign goodEcho = (pairResponse[`FRAME_WIDTH-1:`ECHO_IGNORE_BITS] ==
                      pairRequest[`FRAME_WIDTH-1:`ECHO_IGNORE_BITS]);

   // rule decode, first match wins
   always_comb
   begin
      if (pairRequest == trimPattern)
      begin
         ruleSel = ruleTrim;
      end
      else if (inSdoRange && (pairRequest.cmd == `CMD_READ_REQ))
      begin
         ruleSel = ruleSdoRead;
      end
      else if (inSdoRange && (pairRequest.cmd == `CMD_WRITE_REQ))
      begin
         ruleSel = ruleSdoWrite;
      end
      else
      begin
         ruleSel = ruleEcho;
      end
   end

   always_comb
   begin
      case (ruleSel)
         ruleTrim:
         begin
            goodSel = goodTrim;
         end
         ruleSdoRead:
         begin
            goodSel = goodRead;
         end
         ruleSdoWrite:
         begin
            goodSel = goodWrite;
         end
         default:
         begin
            goodSel = goodEcho;
         end
      endcase
   end

   // verdict register, one cycle after pairValid
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         verdictValid <= 1'b0;
         verdictGood  <= 1'b0;
      end
      else
      begin
         verdictValid <= pairValid;
         if (pairValid)
         begin
            verdictGood <= goodSel;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (pairValid)
      begin
         verdictRule <= ruleSel;   // held until the next pair
      end
   end

endmodule

// ==== hdl/verdictTally.sv ====
// Verdict tally of the CANopen activity monitor
// Counts good and bad verdicts in two counters that stop at their
// maximum value instead of wrapping.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module verdictTally
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    verdictValid,
   input  logic                    verdictGood,
   output logic [`COUNT_WIDTH-1:0] goodCount,
   output logic [`COUNT_WIDTH-1:0] badCount
);

   localparam logic [`COUNT_WIDTH-1:0] countMax = '1;

   logic goodHit;
   logic badHit;

   // at most one of these per cycle
   assign goodHit = verdictValid && verdictGood;
   assign badHit  = verdictValid && !verdictGood;

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         goodCount <= '0;
      end
      else if (goodHit && (goodCount != countMax))
      begin
         goodCount <= goodCount + 1'b1;
      end
   end

   // failure count, the monitor's main figure of merit
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         badCount <= '0;
      end
      else if (badHit && (badCount != countMax))
      begin
         badCount <= badCount + 1'b1;
      end
   end

endmodule

// ==== hdl/canActivityTop.sv ====
// CANopen bus activity monitor, top level
// Pairs each response frame on the hub with the request before it,
// judges the pair by rule class and counts good and bad verdicts.
// Verdict follows a response strobe by two cycles.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module canActivityTop
   import canMonPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic [7:0]              busId,
   input  testModeT                testMode,
   input  frameT                   uplinkFrame,
   input  frameT                   downlinkFrame,
   input  frameT                   decodedFrame,
   input  logic                    reqMsg,
   input  logic                    respMsg,
   output logic                    verdictValid,
   output logic                    verdictGood,
   output ruleT                    verdictRule,
   output logic [`COUNT_WIDTH-1:0] goodCount,
   output logic [`COUNT_WIDTH-1:0] badCount
);

   frameT pairRequest;
   frameT pairResponse;
   logic  pairValid;

   frameCapture capture0
   (
      .clk           (clk),
      .rst           (rst),
      .testMode      (testMode),
      .uplinkFrame   (uplinkFrame),
      .downlinkFrame (downlinkFrame),
      .decodedFrame  (decodedFrame),
      .reqMsg        (reqMsg),
      .respMsg       (respMsg),
      .pairRequest   (pairRequest),
      .pairResponse  (pairResponse),
      .pairValid     (pairValid)
   );

   // busId goes straight to the checker, used by the trim rule
   sdoRuleCheck check0
   (
      .clk          (clk),
      .rst          (rst),
      .busId        (busId),
      .pairRequest  (pairRequest),
      .pairResponse (pairResponse),
      .pairValid    (pairValid),
      .verdictValid (verdictValid),
      .verdictGood  (verdictGood),
      .verdictRule  (verdictRule)
   );

   verdictTally tally0
   (
      .clk          (clk),
      .rst          (rst),
      .verdictValid (verdictValid),
      .verdictGood  (verdictGood),
      .goodCount    (goodCount),
      .badCount     (badCount)
   );

endmodule

// ==== dv/canActivity_properties.sv ====
// Timing properties of the CANopen activity monitor
// Bound to the top level. Checks the verdict latency, quiet outputs
// in reset and a failure count that never goes down.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module canActivityProperties
(
   input logic                    clk,
   input logic                    rst,
   input logic                    respMsg,
   input logic                    verdictValid,
   input logic [`COUNT_WIDTH-1:0] badCount
);

   // fixed two cycle latency, one per pipeline stage
   verdictLatency: assert property (@(posedge clk) disable iff (!rst)
      respMsg |-> ##2 verdictValid)
      else $error("verdictValid did not follow respMsg two cycles later");

   noVerdictInReset: assert property (@(posedge clk) !rst |=> !verdictValid)
      else $error("verdictValid pulsed while the monitor was held in reset");

   // saturating counter, so it can only hold or grow
   badCountRising: assert property (@(posedge clk) disable iff (!rst)
      badCount >= $past(badCount))
      else $error("badCount went down outside reset");

endmodule

bind canActivityTop canActivityProperties props0
(
   .clk          (clk),
   .rst          (rst),
   .respMsg      (respMsg),
   .verdictValid (verdictValid),
   .badCount     (badCount)
);

// ==== dv/canActivityTb.sv ====
// Testbench for the CANopen activity monitor
// Directed tests of the trim, SDO read, SDO write and echo rules,
// back-to-back strobes and reset, checked against a model of the rules.

`timescale 1ns/10ps

`include "canmon_settings.svh"

module canActivityTb
   import canMonPkg::*;
();

   logic                    clk;
   logic                    rst;
   logic [7:0]              busId;
   testModeT                testMode;
   frameT                   uplinkFrame;
   frameT                   downlinkFrame;
   frameT                   decodedFrame;
   logic                    reqMsg;
   logic                    respMsg;
   logic                    verdictValid;
   logic                    verdictGood;
   ruleT                    verdictRule;
   logic [`COUNT_WIDTH-1:0] goodCount;
   logic [`COUNT_WIDTH-1:0] badCount;
   logic [`COUNT_WIDTH-1:0] modelGood;   // expected counter values
   logic [`COUNT_WIDTH-1:0] modelBad;
   int                      errorCount;

   canActivityTop dut0 (.*);

   always #10 clk = ~clk;

   task automatic stopOnError();
      errorCount++;
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // expected verdict from the rule table, first match wins
   function automatic void modelJudge(input frameT req, input frameT resp,
                                      output logic good, output ruleT rule);
      frameT trimFrame;
      logic  sdoNode;
      logic  sameObject;
      trimFrame  = {12'h555, {8{8'hAA}}};
      sdoNode    = (req.cobId >= 12'h601) && (req.cobId <= 12'h67F);
      sameObject = (resp.cobId == req.cobId - 12'h080) && (resp.index == req.index) &&
                   (resp.subIndex == req.subIndex);
      if (req == trimFrame)
      begin
         rule = ruleTrim;
         trimFrame.value[31:24] = busId;   // bus id replaces the top value byte
         good = (resp == trimFrame);
      end
      else if (sdoNode && (req.cmd == 8'h40))
      begin
         rule = ruleSdoRead;
         good = sameObject && (resp.cmd == 8'h43);
      end
      else if (sdoNode && (req.cmd == 8'h23))
      begin
         rule = ruleSdoWrite;
         good = sameObject && (resp.cmd == 8'h60) && (resp.value == 32'h0);
      end
      else
      begin
         rule = ruleEcho;
         good = (resp[75:8] == req[75:8]);
      end
   endfunction

   function automatic frameT pickRequest(input testModeT mode, input frameT up,
                                         input frameT down, input frameT dec);
      if (mode == modeOscTrim)
         return {12'h555, {8{8'hAA}}};
      else if (mode == modeTx)
         return down;
      else if (mode == modeCustom)
         return dec;
      return up;   // normal and rx
   endfunction

   function automatic frameT randomFrame();
      logic [95:0] bits;
      bits = {$urandom(), $urandom(), $urandom()};
      return bits[`FRAME_WIDTH-1:0];
   endfunction

   task automatic waitVerdict(input string name);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!verdictValid && (cycles < 20));
      if (!verdictValid)
      begin
         $display("%s: no verdict came from the monitor within 20 cycles", name);
         stopOnError();
      end
   endtask

   task automatic checkVerdict(input string name, input logic expGood, input ruleT expRule);
      assert (verdictRule == expRule)
      else
      begin
         $display("[ERROR] %s: verdictRule expected %s, actual %s", name, expRule.name(),
                  verdictRule.name());
         stopOnError();
      end
      assert (verdictGood == expGood)
      else
      begin
         $display("[ERROR] %s: verdictGood expected %0b, actual %0b", name, expGood,
                  verdictGood);
         stopOnError();
      end
      if (expGood)
         modelGood = modelGood + 1'b1;
      else
         modelBad = modelBad + 1'b1;
   endtask

   task automatic checkCounts(input string name);
      assert (goodCount == modelGood)
      else
      begin
         $display("[ERROR] %s: goodCount expected %0d, actual %0d", name, modelGood, goodCount);
         stopOnError();
      end
      assert (badCount == modelBad)
      else
      begin
         $display("[ERROR] %s: badCount expected %0d, actual %0d", name, modelBad, badCount);
         stopOnError();
      end
   endtask

   // one request, then its response on the uplink, then the checks
   task automatic runPair(input string name, input testModeT mode, input frameT up,
                          input frameT down, input frameT dec, input frameT resp);
      logic expGood;
      ruleT expRule;
      @(posedge clk);
      testMode      <= mode;
      uplinkFrame   <= up;
      downlinkFrame <= down;
      decodedFrame  <= dec;
      reqMsg        <= 1'b1;
      @(posedge clk);
      reqMsg      <= 1'b0;
      uplinkFrame <= resp;
      respMsg     <= 1'b1;
      @(posedge clk);
      respMsg <= 1'b0;
      waitVerdict(name);
      modelJudge(pickRequest(mode, up, down, dec), resp, expGood, expRule);
      checkVerdict(name, expGood, expRule);
      @(negedge clk);   // counters move one cycle after the verdict
      checkCounts(name);
   endtask

   task automatic trimRuleTest();
      frameT resp;
      @(posedge clk);
      busId <= 8'($urandom());
      @(posedge clk);
      resp = {12'h555, {8{8'hAA}}};
      resp.value[31:24] = busId;
      runPair("trim good", modeOscTrim, randomFrame(), randomFrame(), randomFrame(), resp);
      resp.value[31:24] = ~busId;
      runPair("trim wrong bus id", modeOscTrim, randomFrame(), randomFrame(), randomFrame(),
              resp);
   endtask

   task automatic sdoReadTest();
      logic [11:0] node;
      frameT       req;
      frameT       resp;
      node = 12'($urandom_range(127, 1));
      req  = {12'h600 + node, 8'h40, 16'($urandom()), 8'($urandom()), 32'h0};
      resp = {12'h580 + node, 8'h43, req.index, req.subIndex, $urandom()};
      runPair("sdo read good", modeNormal, req, randomFrame(), randomFrame(), resp);
      resp.cobId = resp.cobId + 12'h001;
      runPair("sdo read wrong cob id", modeNormal, req, randomFrame(), randomFrame(), resp);
      resp.cobId = resp.cobId - 12'h001;
      resp.cmd   = 8'h4B;
      runPair("sdo read wrong cmd", modeNormal, req, randomFrame(), randomFrame(), resp);
      resp.cmd      = 8'h43;
      resp.subIndex = ~resp.subIndex;
      runPair("sdo read wrong subindex", modeNormal, req, randomFrame(), randomFrame(), resp);
   endtask

   task automatic sdoWriteTest();
      logic [11:0] node;
      frameT       req;
      frameT       resp;
      node = 12'($urandom_range(127, 1));
      req  = {12'h600 + node, 8'h23, 16'($urandom()), 8'($urandom()), $urandom()};
      resp = {12'h580 + node, 8'h60, req.index, req.subIndex, 32'h0};
      runPair("sdo write ack", modeNormal, req, randomFrame(), randomFrame(), resp);
      resp.value = $urandom() | 32'h1;
      runPair("sdo write nonzero value", modeNormal, req, randomFrame(), randomFrame(), resp);
      resp.value = 32'h0;
      resp.cmd   = 8'h43;
      runPair("sdo write wrong cmd", modeNormal, req, randomFrame(), randomFrame(), resp);
   endtask

   task automatic echoInMode(input string name, input testModeT mode);
      frameT src;
      frameT up;
      frameT down;
      frameT dec;
      frameT resp;
      src     = randomFrame();
      src.cmd = 8'h11;   // no SDO command, so only the echo rule fits
      up      = randomFrame();
      down    = randomFrame();
      dec     = randomFrame();
      if (mode == modeTx)
         down = src;
      else if (mode == modeCustom)
         dec = src;
      else
         up = src;
      resp = src;
      resp.value[7:0] = ~src.value[7:0];
      runPair({name, " low byte only"}, mode, up, down, dec, resp);
      resp.index = resp.index ^ 16'h0100;
      runPair({name, " index changed"}, mode, up, down, dec, resp);
   endtask

   task automatic echoTest();
      echoInMode("echo tx", modeTx);
      echoInMode("echo rx", modeRx);
      echoInMode("echo custom", modeCustom);
   endtask

   // requests on the downlink, responses on the uplink, strobes every cycle
   task automatic backToBackTest();
      frameT reqs[3];
      frameT resps[3];
      frameT reqB;
      logic  expGood;
      ruleT  expRule;
      reqB     = randomFrame();
      reqB.cmd = 8'h11;
      reqs[0]  = {12'h605, 8'h40, 16'h2000, 8'h01, 32'h0};
      reqs[1]  = reqs[0];   // same-cycle response still pairs with the older request
      reqs[2]  = reqB;
      resps[0] = {12'h585, 8'h43, 16'h2000, 8'h01, $urandom()};
      resps[1] = resps[0];
      resps[1].cmd = 8'h4F;
      resps[2] = reqB;
      resps[2].value[7:0] = 8'h00;
      fork
         begin
            @(posedge clk);
            testMode      <= modeTx;
            downlinkFrame <= reqs[0];
            reqMsg        <= 1'b1;
            @(posedge clk);
            reqMsg      <= 1'b0;
            uplinkFrame <= resps[0];
            respMsg     <= 1'b1;
            @(posedge clk);
            downlinkFrame <= reqB;
            reqMsg        <= 1'b1;
            uplinkFrame   <= resps[1];
            @(posedge clk);
            reqMsg      <= 1'b0;
            uplinkFrame <= resps[2];
            @(posedge clk);
            respMsg <= 1'b0;
         end
         begin
            // first verdict shows up while the last strobe is still high
            for (int i = 0; i < 3; i++)
            begin
               waitVerdict("back to back");
               modelJudge(reqs[i], resps[i], expGood, expRule);
               checkVerdict("back to back", expGood, expRule);
            end
         end
      join
      @(negedge clk);
      checkCounts("back to back");
   endtask

   task automatic resetTest();
      frameT resp;
      logic  expGood;
      ruleT  expRule;
      @(posedge clk);
      rst <= 1'b0;
      repeat (4) @(posedge clk);
      rst       <= 1'b1;
      modelGood = '0;
      modelBad  = '0;
      @(negedge clk);
      assert (!verdictValid)
      else
      begin
         $display("verdictValid was high right after reset");
         stopOnError();
      end
      checkCounts("after reset");
      resp = '0;
      resp.value[7:0] = 8'h5A;   // only the ignored byte is nonzero
      @(posedge clk);
      uplinkFrame <= resp;
      respMsg     <= 1'b1;
      @(posedge clk);
      respMsg <= 1'b0;
      waitVerdict("response before request");
      modelJudge('0, resp, expGood, expRule);
      checkVerdict("response before request", expGood, expRule);
      @(negedge clk);
      checkCounts("response before request");
   endtask

   initial
   begin
      void'($urandom(60));
      clk           = 1'b0;
      errorCount    = 0;
      modelGood     = '0;
      modelBad      = '0;
      rst           <= 1'b0;
      busId         <= 8'h00;
      testMode      <= modeNormal;
      uplinkFrame   <= '0;
      downlinkFrame <= '0;
      decodedFrame  <= '0;
      reqMsg        <= 1'b0;
      respMsg       <= 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b1;
      trimRuleTest();
      sdoReadTest();
      sdoWriteTest();
      echoTest();
      backToBackTest();
      resetTest();
      if (errorCount == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/canMonPkg.sv
hdl/frameCapture.sv
hdl/sdoRuleCheck.sv
hdl/verdictTally.sv
hdl/canActivityTop.sv
dv/canActivity_properties.sv
dv/canActivityTb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CANopen activity monitor testbench with Verilator.
# The result is taken from the pass message in the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module canActivityTb \
   -o simv > build.log 2>&1 \
   && ./obj_dir/simv > "$LOG" 2>&1 \
   || { echo "build or simulation failed, see build.log and $LOG"; exit 1; }

grep -q "All tests passed!" "$LOG" \
   && echo "simulation passed" \
   || { echo "simulation failed, see $LOG"; exit 1; }
